/* source/decode_consts.svh */
// Instruction field positions, widths and pipeline constants for the decode stage, included by its sources
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

`define DEC_XLEN      32    // Instruction and PC width
`define DEC_REG_W     5     // Register index
`define DEC_SRC_W     6     // Source select, one bit wider so it can name the PC
`define DEC_SRC_PC    6'd32 // Source select value that means "use the PC"
`define DEC_IMM_W     16
`define DEC_IDX_W     26    // J / JAL target index
`define DEC_OP_W      6     // Decoded opcode enum width
`define DEC_ALU_W     5     // ALU operation width

// Link value added to the PC by JAL and JALR
`define DEC_LINK_OFS  16'd4
`define DEC_LINK_REG  5'd31

// Execute stage buffer depth and the width of the counter that tracks it
`define DEC_CREDITS   4
`define DEC_CRED_W    3

// Bit positions inside the instruction word
`define DEC_OPC_MSB   31
`define DEC_OPC_LSB   26
`define DEC_RS_MSB    25
`define DEC_RS_LSB    21
`define DEC_RT_MSB    20
`define DEC_RT_LSB    16
`define DEC_RD_MSB    15
`define DEC_RD_LSB    11
`define DEC_SA_MSB    10
`define DEC_SA_LSB    6
`define DEC_FN_MSB    5
`define DEC_FN_LSB    0

`endif

/* source/decode_pkg.sv */
// Opcode, ALU and jump enums plus the control structs shared by the decode RTL and its testbench
`include "decode_consts.svh"

package decode_pkg;

	// One value per supported instruction
	typedef enum logic [`DEC_OP_W-1:0] {
		OP_NOP, OP_UNDEF,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU,
		OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
		OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ,
		OP_J, OP_JAL, OP_JR, OP_JALR,
		OP_LB, OP_LBU, OP_LW, OP_SB, OP_SW
	} op_e;

	// Encodings as the execute stage ALU expects them
	typedef enum logic [`DEC_ALU_W-1:0] {
		ALU_SLL       = 5'b00000,
		ALU_SRL       = 5'b00001,
		ALU_SRA       = 5'b00010,
		ALU_ADD       = 5'b01000,
		ALU_ADDU      = 5'b01001,
		ALU_SUB       = 5'b01010, // SUBU shares it
		ALU_AND       = 5'b01100,
		ALU_OR        = 5'b01101,
		ALU_XOR       = 5'b01110,
		ALU_NOR       = 5'b01111,
		ALU_SLT       = 5'b10000,
		ALU_SLTU      = 5'b10001,
		ALU_LUI       = 5'b10010,
		ALU_BEQ       = 5'b10011,
		ALU_BLTZ_BGEZ = 5'b10100, // Pair told apart by which operand carries rs
		ALU_BNE       = 5'b10101,
		ALU_BLEZ_BGTZ = 5'b10110
	} alu_op_e;

	typedef enum logic [1:0] {
		JMP_NONE  = 2'd0,
		JMP_INDEX = 2'd1, // PC region plus 26-bit index
		JMP_REG   = 2'd2  // Target from src2
	} jump_e;

	typedef struct packed {
		logic en;
		logic write;     // Store when set, else load
		logic byte_mode; // Byte access, else word
		logic sign_ext;  // Sign extend loaded byte
	} mem_ctrl_t;

	typedef struct packed {
		logic en;
		logic from_alu; // Clear means result comes from memory
	} wb_ctrl_t;

	typedef struct packed {
		logic [`DEC_XLEN-1:0] insn;
		logic [`DEC_XLEN-1:0] pc;
	} dec_in_t;

	// Control word handed to execute
	typedef struct packed {
		op_e                   op;
		logic [`DEC_SRC_W-1:0] src1;
		logic [`DEC_SRC_W-1:0] src2;
		logic [`DEC_REG_W-1:0] dst;
		logic [`DEC_IMM_W-1:0] imm;   // Raw, execute does the extension
		alu_op_e               alu_op;
		logic                  b_imm; // ALU B input from imm instead of src2
		mem_ctrl_t             mem;
		wb_ctrl_t              wb;
		jump_e                 jump;
		logic [`DEC_IDX_W-1:0] idx;
		logic [`DEC_XLEN-1:0]  pc;
	} dec_ctrl_t;

endpackage

/* source/insn_classifier.sv */
// Combinational decode of a raw instruction word into the opcode enum, used between the two decode stages
`timescale 1ns/1ps
`include "decode_consts.svh"

module insn_classifier
	import decode_pkg::*;
(
	input  logic [`DEC_XLEN-1:0] insn,
	output op_e                  op
);

	logic [5:0]            opc;
	logic [`DEC_REG_W-1:0] rt;
	logic [`DEC_REG_W-1:0] rd;
	logic [`DEC_REG_W-1:0] sa;
	logic [5:0]            fn;

	assign opc = insn[`DEC_OPC_MSB:`DEC_OPC_LSB];
	assign rt  = insn[`DEC_RT_MSB:`DEC_RT_LSB];
	assign rd  = insn[`DEC_RD_MSB:`DEC_RD_LSB];
	assign sa  = insn[`DEC_SA_MSB:`DEC_SA_LSB];
	assign fn  = insn[`DEC_FN_MSB:`DEC_FN_LSB];

	always_comb
	begin
		op = OP_UNDEF; // Anything not matched below
		case (opc)
			6'h00:
			begin
				// SPECIAL group, selected by funct
				case (fn)
					// SLL with nothing to shift into is a NOP, whatever rs holds
					6'h00: op = (rt == '0 && rd == '0 && sa == '0) ? OP_NOP : OP_SLL;
					6'h02: op = OP_SRL;
					6'h03: op = OP_SRA;
					6'h04: op = OP_SLLV;
					6'h06: op = OP_SRLV;
					6'h07: op = OP_SRAV;
					6'h08: op = OP_JR;
					6'h09: op = OP_JALR;
					6'h20: op = OP_ADD;
					6'h21: op = OP_ADDU;
					6'h22: op = OP_SUB;
					6'h23: op = OP_SUBU;
					6'h24: op = OP_AND;
					6'h25: op = OP_OR;
					6'h26: op = OP_XOR;
					6'h27: op = OP_NOR;
					6'h2a: op = OP_SLT;
					6'h2b: op = OP_SLTU;
					default: op = OP_UNDEF; // MUL/DIV/HI/LO land here
				endcase
			end
			6'h01:
			begin
				// REGIMM, rt picks the branch
				if (rt == 5'd0)
					op = OP_BLTZ;
				else if (rt == 5'd1)
					op = OP_BGEZ;
			end
			6'h02: op = OP_J;
			6'h03: op = OP_JAL;
			6'h04: op = OP_BEQ;
			6'h05: op = OP_BNE;
			6'h06: op = OP_BLEZ;
			6'h07: op = OP_BGTZ;
			6'h09: op = OP_ADDIU;
			6'h0a: op = OP_SLTI;
			6'h0b: op = OP_SLTIU;
			6'h0c: op = OP_ANDI;
			6'h0d: op = OP_ORI;
			6'h0e: op = OP_XORI;
			6'h0f: op = OP_LUI;
			6'h20: op = OP_LB;
			6'h23: op = OP_LW;
			6'h24: op = OP_LBU;
			6'h28: op = OP_SB;
			6'h2b: op = OP_SW;
			default: op = OP_UNDEF; // SH and MUL opcodes included
		endcase
	end

	// A known word from stage 1 must always classify to a known opcode
	a_op_known: assert property (@(insn) !$isunknown(insn) |-> !$isunknown(op))
		else $error("insn_classifier: unknown opcode for insn %h", insn);

endmodule

/* source/ctrl_gen.sv */
// Combinational build of the execute control word from the decoded opcode and the stage 1 word
`timescale 1ns/1ps
`include "decode_consts.svh"

module ctrl_gen
	import decode_pkg::*;
(
	input  op_e       op,
	input  dec_in_t   in_data,
	output dec_ctrl_t ctrl
);

	logic [`DEC_SRC_W-1:0] rs_sel; // Register fields widened to source select
	logic [`DEC_SRC_W-1:0] rt_sel;
	logic [`DEC_REG_W-1:0] rt;
	logic [`DEC_REG_W-1:0] rd;
	logic [`DEC_IMM_W-1:0] imm16;
	logic [`DEC_IMM_W-1:0] shamt; // Shift amount placed in the immediate

	assign rt     = in_data.insn[`DEC_RT_MSB:`DEC_RT_LSB];
	assign rd     = in_data.insn[`DEC_RD_MSB:`DEC_RD_LSB];
	assign rs_sel = {1'b0, in_data.insn[`DEC_RS_MSB:`DEC_RS_LSB]};
	assign rt_sel = {1'b0, rt};
	assign imm16  = in_data.insn[`DEC_IMM_W-1:0];
	assign shamt  = {{(`DEC_IMM_W-`DEC_REG_W){1'b0}}, in_data.insn[`DEC_SA_MSB:`DEC_SA_LSB]};

	// ALU operation per opcode
	function automatic alu_op_e alu_of(input op_e o);
		case (o)
			OP_SRL, OP_SRLV:                    return ALU_SRL;
			OP_SRA, OP_SRAV:                    return ALU_SRA;
			OP_ADD, OP_LB, OP_LBU, OP_LW,
			OP_SB, OP_SW, OP_ADDIU:             return ALU_ADD; // Address add for memory ops
			OP_ADDU, OP_J, OP_JAL, OP_JALR:     return ALU_ADDU; // Link is PC + 4
			OP_SUB, OP_SUBU:                    return ALU_SUB;
			OP_AND, OP_ANDI:                    return ALU_AND;
			OP_OR, OP_ORI:                      return ALU_OR;
			OP_XOR, OP_XORI:                    return ALU_XOR;
			OP_NOR:                             return ALU_NOR;
			OP_SLT, OP_SLTI:                    return ALU_SLT;
			OP_SLTU, OP_SLTIU:                  return ALU_SLTU;
			OP_LUI:                             return ALU_LUI;
			OP_BEQ:                             return ALU_BEQ;
			OP_BNE:                             return ALU_BNE;
			OP_BLEZ, OP_BGTZ:                   return ALU_BLEZ_BGTZ;
			OP_BLTZ, OP_BGEZ:                   return ALU_BLTZ_BGEZ;
			default:                            return ALU_SLL; // SLL, SLLV, JR, NOP, UNDEF
		endcase
	endfunction

	always_comb
	begin
		// Quiet word, no enables
		ctrl        = '0;
		ctrl.op     = op;
		ctrl.pc     = in_data.pc; // PC always rides along
		ctrl.alu_op = alu_of(op);
		ctrl.jump   = JMP_NONE;

		case (op)
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
			OP_SLT, OP_SLTU, OP_SLLV, OP_SRLV, OP_SRAV:
			begin
				ctrl.src1 = rs_sel;
				ctrl.src2 = rt_sel;
				ctrl.dst  = rd;
				ctrl.wb   = '{en: 1'b1, from_alu: 1'b1};
			end
			OP_SLL, OP_SRL, OP_SRA:
			begin
				ctrl.src1  = rt_sel; // Value to shift
				ctrl.dst   = rd;
				ctrl.imm   = shamt;
				ctrl.b_imm = 1'b1;
				ctrl.wb    = '{en: 1'b1, from_alu: 1'b1};
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
			begin
				ctrl.src1  = (op == OP_LUI) ? '0 : rs_sel; // LUI has no register input
				ctrl.dst   = rt;
				ctrl.imm   = imm16;
				ctrl.b_imm = 1'b1;
				ctrl.wb    = '{en: 1'b1, from_alu: 1'b1};
			end
			OP_BEQ, OP_BNE:
			begin
				ctrl.src1 = rs_sel;
				ctrl.src2 = rt_sel;
				ctrl.imm  = imm16;
			end
			OP_BLEZ, OP_BLTZ:
			begin
				ctrl.src1 = rs_sel; // rs on A side
				ctrl.imm  = imm16;
			end
			OP_BGTZ, OP_BGEZ:
			begin
				ctrl.src2 = rs_sel; // rs on B side flips the compare
				ctrl.imm  = imm16;
			end
			OP_J:
			begin
				ctrl.jump = JMP_INDEX;
				ctrl.idx  = in_data.insn[`DEC_IDX_W-1:0];
			end
			OP_JAL, OP_JALR:
			begin
				// Link value PC + 4 computed by the ALU
				ctrl.src1  = `DEC_SRC_PC;
				ctrl.imm   = `DEC_LINK_OFS;
				ctrl.b_imm = 1'b1;
				ctrl.wb    = '{en: 1'b1, from_alu: 1'b1};
				if (op == OP_JAL)
				begin
					ctrl.dst  = `DEC_LINK_REG;
					ctrl.jump = JMP_INDEX;
					ctrl.idx  = in_data.insn[`DEC_IDX_W-1:0];
				end
				else
				begin
					ctrl.src2 = rs_sel; // Jump target register
					ctrl.dst  = rd;
					ctrl.jump = JMP_REG;
				end
			end
			OP_JR:
			begin
				ctrl.src2 = rs_sel;
				ctrl.jump = JMP_REG;
			end
			OP_LB, OP_LBU, OP_LW:
			begin
				ctrl.src1  = rs_sel; // Base
				ctrl.dst   = rt;
				ctrl.imm   = imm16;  // Offset
				ctrl.b_imm = 1'b1;
				ctrl.mem   = '{en: 1'b1, write: 1'b0, byte_mode: (op != OP_LW),
				               sign_ext: (op == OP_LB)};
				ctrl.wb    = '{en: 1'b1, from_alu: 1'b0};
			end
			OP_SB, OP_SW:
			begin
				ctrl.src1  = rs_sel;
				ctrl.src2  = rt_sel; // Store data
				ctrl.imm   = imm16;
				ctrl.b_imm = 1'b1;
				ctrl.mem   = '{en: 1'b1, write: 1'b1, byte_mode: (op == OP_SB), sign_ext: 1'b0};
			end
			default:
			begin
				// NOP and UNDEF keep the quiet word
			end
		endcase
	end

endmodule

/* source/decode_pipe.sv */
// Two-stage decode pipeline with valid/ready input and credit flow control toward execute
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_pipe
	import decode_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	input  dec_in_t   in_data,
	output logic      in_ready,
	output dec_in_t   s1_data,    // To the classifier and control generator
	input  dec_ctrl_t next_ctrl,  // Decoded word for the stage 1 entry
	input  logic      credit_ret, // One pulse per slot freed downstream
	output logic      out_valid,
	output dec_ctrl_t out_ctrl
);

	logic                   s1_valid;
	logic                   s2_valid;
	dec_in_t                s1_q;
	dec_ctrl_t              s2_q;
	logic [`DEC_CRED_W-1:0] credits;  // Free slots in the execute buffer
	logic                   s2_free;  // Stage 2 can take a new word this cycle
	logic                   in_fire;

	assign out_valid = s2_valid && (credits != '0);
	assign out_ctrl  = s2_q;
	assign s1_data   = s1_q;

	// Stage 2 empties when it is empty already or sends this cycle
	assign s2_free  = !s2_valid || out_valid;
	assign in_ready = !s1_valid || s2_free; // Stage 1 empty or moving on
	assign in_fire  = in_valid && in_ready;

	// Stage 1 holds the raw word
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s1_q     <= '0;
		end
		else if (in_fire)
		begin
			s1_valid <= 1'b1;
			s1_q     <= in_data;
		end
		else if (s2_free)
			s1_valid <= 1'b0; // Moved to stage 2 with nothing behind it
	end

	// Stage 2 holds the control word until a credit lets it go
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s2_valid <= 1'b0;
			s2_q     <= '0;
		end
		else if (s2_free)
		begin
			s2_valid <= s1_valid;
			if (s1_valid)
				s2_q <= next_ctrl;
		end
	end

	// Spend on each send, refill on each return, both may happen together
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			credits <= `DEC_CRED_W'(`DEC_CREDITS);
		else
			credits <= credits + `DEC_CRED_W'(credit_ret) - `DEC_CRED_W'(out_valid);
	end

	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= `DEC_CREDITS)
		else $error("decode_pipe: credit count %0d above buffer depth", credits);

	// Spending the last credit with none coming back must stall the next cycle
	a_no_send_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && credits == `DEC_CRED_W'(1) && !credit_ret |=> !out_valid)
		else $error("decode_pipe: send without a credit");

	// Downstream can only free a slot that was filled
	a_no_spurious_ret: assert property (@(posedge clk) disable iff (!rst_n)
		credit_ret |-> credits != `DEC_CRED_W'(`DEC_CREDITS))
		else $error("decode_pipe: credit returned with the count full");

endmodule

/* source/decode_top.sv */
// Top level of the decode stage, joins the pipeline with the classifier and control generator
`timescale 1ns/1ps

module decode_top
	import decode_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	input  dec_in_t   in_data,
	output logic      in_ready,
	output logic      out_valid,
	output dec_ctrl_t out_ctrl,
	input  logic      credit_ret
);

	op_e       op;        // Classified stage 1 instruction
	dec_in_t   s1_data;
	dec_ctrl_t next_ctrl; // Into stage 2

	insn_classifier i_classifier (
		.insn (s1_data.insn),
		.op   (op)
	);

	ctrl_gen i_ctrl_gen (
		.op      (op),
		.in_data (s1_data),
		.ctrl    (next_ctrl)
	);

	decode_pipe i_pipe (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.s1_data    (s1_data),
		.next_ctrl  (next_ctrl),
		.credit_ret (credit_ret),
		.out_valid  (out_valid),
		.out_ctrl   (out_ctrl)
	);

endmodule

/* bench/tb_decode.sv */
// Testbench for the decode stage that replays the stimulus file and checks each control word in order
`timescale 1ns/1ps
`include "decode_consts.svh"

module tb_decode
	import decode_pkg::*;
();

	localparam logic [31:0] SEED = 32'h7c23_c440;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	dec_in_t   in_data;
	logic      in_ready;
	logic      out_valid;
	dec_ctrl_t out_ctrl;
	logic      credit_ret;

	dec_in_t     in_q[$];          // Words still to offer
	dec_ctrl_t   exp_q[$];         // Expected words in input order
	int          total   = 0;      // Entries read from the file
	int          sent    = 0;
	int          checked = 0;
	int          slots   = 0;      // Fill of the model execute buffer
	int          sends   = 0;      // out_valid cycles seen
	int          returns = 0;      // credit_ret pulses given
	logic [31:0] rng_in  = SEED;   // Input gap stream
	logic [31:0] rng_out = SEED ^ 32'h0000_ffff; // Credit return stream

	decode_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_ctrl   (out_ctrl),
		.credit_ret (credit_ret)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_op(input string name, input op_e exp, input op_e act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected %s actual %s", name, exp.name(), act.name()));
	endtask

	task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected %s actual %s", name, exp.name(), act.name()));
	endtask

	task automatic check_mem(input string name, input mem_ctrl_t exp, input mem_ctrl_t act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_wb(input string name, input wb_ctrl_t exp, input wb_ctrl_t act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_jump(input string name, input jump_e exp, input jump_e act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected %s actual %s", name, exp.name(), act.name()));
	endtask

	task automatic check_vec(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
	endtask

	// Field by field so a mismatch names the field
	task automatic check_ctrl(input int k, input dec_ctrl_t exp, input dec_ctrl_t act);
		string t;
		t = $sformatf("entry %0d pc %h", k, exp.pc);
		check_op({t, " op"}, exp.op, act.op);
		check_alu({t, " alu_op"}, exp.alu_op, act.alu_op);
		check_vec({t, " src1"}, 32'(exp.src1), 32'(act.src1));
		check_vec({t, " src2"}, 32'(exp.src2), 32'(act.src2));
		check_vec({t, " dst"}, 32'(exp.dst), 32'(act.dst));
		check_vec({t, " imm"}, 32'(exp.imm), 32'(act.imm));
		check_vec({t, " b_imm"}, 32'(exp.b_imm), 32'(act.b_imm));
		check_mem({t, " mem"}, exp.mem, act.mem);
		check_wb({t, " wb"}, exp.wb, act.wb);
		check_jump({t, " jump"}, exp.jump, act.jump);
		check_vec({t, " idx"}, 32'(exp.idx), 32'(act.idx));
		check_vec({t, " pc"}, exp.pc, act.pc);
	endtask

	// One entry per data line while comment lines fail the scan and drop out
	task automatic load_stimulus();
		int          fd;
		int          n;
		string       line;
		logic [31:0] insn, pc, f_op, f_alu, f_src1, f_src2, f_dst;
		logic [31:0] f_imm, f_bimm, f_mem, f_wb, f_jump, f_idx;
		dec_in_t     d;
		dec_ctrl_t   e;
		fd = $fopen("bench/decode_stimulus.txt", "r");
		if (fd == 0)
			abort_run("Could not open the stimulus file bench/decode_stimulus.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", insn, pc, f_op, f_alu,
				f_src1, f_src2, f_dst, f_imm, f_bimm, f_mem, f_wb, f_jump, f_idx);
			if (n == 13)
			begin
				d.insn   = insn;
				d.pc     = pc;
				e        = '0;
				e.op     = op_e'(f_op[`DEC_OP_W-1:0]);
				e.alu_op = alu_op_e'(f_alu[`DEC_ALU_W-1:0]);
				e.src1   = f_src1[`DEC_SRC_W-1:0];
				e.src2   = f_src2[`DEC_SRC_W-1:0];
				e.dst    = f_dst[`DEC_REG_W-1:0];
				e.imm    = f_imm[`DEC_IMM_W-1:0];
				e.b_imm  = f_bimm[0];
				e.mem    = mem_ctrl_t'(f_mem[3:0]); // {en, write, byte, sign}
				e.wb     = wb_ctrl_t'(f_wb[1:0]);
				e.jump   = jump_e'(f_jump[1:0]);
				e.idx    = f_idx[`DEC_IDX_W-1:0];
				e.pc     = pc; // Must come out unchanged
				in_q.push_back(d);
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
		if (exp_q.size() == 0)
			abort_run("The stimulus file holds no entries");
		total = exp_q.size();
	endtask

	initial
	begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_data    = '0;
		credit_ret = 1'b0;
		load_stimulus();
		repeat (4) @(posedge clk);
		@(negedge clk);
		// Empty pipe takes input and sends nothing
		check_vec("reset in_ready", 32'd1, 32'(in_ready));
		check_vec("reset out_valid", 32'd0, 32'(out_valid));
		rst_n = 1'b1;
		wait (checked == total);
		repeat (10) @(negedge clk); // Room for a stray extra output to show up
		$display("sim passed");
		$finish;
	end

	// Upstream source holding valid until taken with random gaps
	initial
	begin : drive_inputs
		logic took;
		took = 1'b0;
		wait (rst_n);
		while (sent < total)
		begin
			@(negedge clk);
			if (took)
				sent++;
			if (sent == total)
				in_valid = 1'b0;
			else if (took || !in_valid)
			begin
				rng_in   = xorshift(rng_in);
				in_valid = rng_in[1:0] != 2'b00; // Idle about one cycle in four
				in_data  = in_q[sent];
			end
			took = in_valid && in_ready; // in_ready holds until the next rising edge
		end
	end

	// Execute side model that accepts every send and frees slots at random
	initial
	begin : model_downstream
		int had;
		wait (rst_n);
		forever
		begin
			@(negedge clk);
			had = slots; // Only slots filled before this cycle may drain
			// A sending stage 2 frees room for stage 1
			if (out_valid && !in_ready)
				abort_run("The decode stage refused input while stage 2 was sending");
			if (out_valid)
			begin
				if (exp_q.size() == 0)
					abort_run("The decode stage sent a control word with no instruction behind it");
				else if (sends >= `DEC_CREDITS + returns)
					abort_run("The decode stage sent more words than it had credits for");
				else
				begin
					sends++;
					slots++;
					check_ctrl(checked, exp_q.pop_front(), out_ctrl);
					checked++;
				end
			end
			rng_out    = xorshift(rng_out);
			credit_ret = (had > 0) && (rng_out[2:0] < 3'd3);
			if (credit_ret)
			begin
				slots--;
				returns++;
			end
		end
	end

	// Limit grows with the entry count
	initial
	begin
		wait (total > 0);
		#((total * 40 + 200) * 40);
		abort_run("Timeout, not every instruction came out of the decode stage in time");
	end

endmodule

/* bench/decode_stimulus.txt */
// insn pc op alu src1 src2 dst imm b_imm mem wb jump idx, all hex, op and alu as enum codes
// mem is {en,write,byte,sign}, wb is {en,from_alu}, jump 0 none 1 index 2 register
00221820 00400000 02 08 01 02 03 0000 0 0 3 0 0000000
00a62021 00400004 03 09 05 06 04 0000 0 0 3 0 0000000
01093822 00400008 04 0a 08 09 07 0000 0 0 3 0 0000000
016c5023 0040000c 05 0a 0b 0c 0a 0000 0 0 3 0 0000000
01cf6824 00400010 06 0c 0e 0f 0d 0000 0 0 3 0 0000000
02328025 00400014 07 0d 11 12 10 0000 0 0 3 0 0000000
02959826 00400018 08 0e 14 15 13 0000 0 0 3 0 0000000
02f8b027 0040001c 09 0f 17 18 16 0000 0 0 3 0 0000000
035bc82a 00400020 0a 10 1a 1b 19 0000 0 0 3 0 0000000
03bee02b 00400024 0b 11 1d 1e 1c 0000 0 0 3 0 0000000
00031100 00400028 0c 00 03 00 02 0004 1 0 3 0 0000000
00062fc2 0040002c 0d 01 06 00 05 001f 1 0 3 0 0000000
000941c3 00400030 0e 02 09 00 08 0007 1 0 3 0 0000000
00620804 00400034 0f 00 03 02 01 0000 0 0 3 0 0000000
00c52006 00400038 10 01 06 05 04 0000 0 0 3 0 0000000
01283807 0040003c 11 02 09 08 07 0000 0 0 3 0 0000000
00000000 00400040 00 00 00 00 00 0000 0 0 0 0 0000000
00a00000 00400044 00 00 00 00 00 0000 0 0 0 0 0000000
24221234 00400048 12 08 01 00 02 1234 1 0 3 0 0000000
2883ffff 0040004c 13 10 04 00 03 ffff 1 0 3 0 0000000
2cc58000 00400050 14 11 06 00 05 8000 1 0 3 0 0000000
310700ff 00400054 15 0c 08 00 07 00ff 1 0 3 0 0000000
3549a5a5 00400058 16 0d 0a 00 09 a5a5 1 0 3 0 0000000
398b0f0f 0040005c 17 0e 0c 00 0b 0f0f 1 0 3 0 0000000
3c0ddead 00400060 18 12 00 00 0d dead 1 0 3 0 0000000
10220010 00400064 19 13 01 02 00 0010 0 0 0 0 0000000
1464fff0 00400068 1a 15 03 04 00 fff0 0 0 0 0 0000000
18a00020 0040006c 1b 16 05 00 00 0020 0 0 0 0 0000000
1cc00030 00400070 1c 16 00 06 00 0030 0 0 0 0 0000000
04e00040 00400074 1d 14 07 00 00 0040 0 0 0 0 0000000
05010050 00400078 1e 14 00 08 00 0050 0 0 0 0 0000000
08123456 0040007c 1f 09 00 00 00 0000 0 0 0 1 0123456
0fffffff 00400080 20 09 20 00 1f 0004 1 0 3 1 3ffffff
03e00008 00400084 21 00 00 1f 00 0000 0 0 0 2 0000000
01201009 00400088 22 09 20 09 02 0004 1 0 3 2 0000000
83a20004 0040008c 23 08 1d 00 02 0004 1 b 2 0 0000000
93a3fffc 00400090 24 08 1d 00 03 fffc 1 a 2 0 0000000
8f840100 00400094 25 08 1c 00 04 0100 1 8 2 0 0000000
a3a50008 00400098 26 08 1d 05 00 0008 1 e 0 0 0000000
afa6000c 0040009c 27 08 1d 06 00 000c 1 c 0 0 0000000
00220018 fffffffc 01 00 00 00 00 0000 0 0 0 0 0000000
a7a50002 80000180 01 00 00 00 00 0000 0 0 0 0 0000000
04020010 12345678 01 00 00 00 00 0000 0 0 0 0 0000000

/* sim.f */
+incdir+source
source/decode_pkg.sv
source/insn_classifier.sv
source/ctrl_gen.sv
source/decode_pipe.sv
source/decode_top.sv
bench/tb_decode.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_decode
FILELIST = sim.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
